/* list.f */
+incdir+design
design/mmu_pkg.sv
design/addr_xlate.sv
design/tlb_lookup_ctl.sv
design/tlb_entry.sv
design/tlb_hit_merge.sv
design/mmu_top.sv
dv/mmu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module mmu_tb -f list.f -o mmu_sim
./obj_dir/mmu_sim | tee sim.log
if grep -qF '*** TEST PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

/* dv/mmu_tb.sv */
// table-driven testbench for the MMU top level
// each row is either an indexed TLB write or one access with its expected bus outputs
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_tb import mmu_pkg::*; ();

    typedef struct packed {
        logic                  wr;         // TLB write row
        logic [`TLB_IDX_W-1:0] idx;
        tlb_entry_t            ent;
        logic                  en;
        logic [3:0]            wen;
        logic [`ADDR_W-1:0]    vaddr;      // page base, offset drawn at run time
        logic                  exc_flag;
        logic                  streq;
        logic [`ADDR_W-1:0]    status;
        logic [`ADDR_W-1:0]    cfg;
        logic [`ASID_W-1:0]    asid;
        logic                  mapped;     // one TLB stall cycle expected
        logic                  exp_bus_en;
        logic [`ADDR_W-1:0]    exp_pa;     // frame base
        logic                  exp_cached;
        logic [2:0]            exp_exc;    // tlbr, tlbi, tlbm
    } vec_t;

    logic                  clk;
    logic                  rst;
    mem_req_t              req;
    logic [`ADDR_W-1:0]    rdata;
    logic                  exc_flag;
    logic [`ADDR_W-1:0]    cp0_status;
    logic [`ADDR_W-1:0]    cp0_config;
    logic [`ASID_W-1:0]    asid;
    logic                  tlbw_en;
    logic [`TLB_IDX_W-1:0] tlbw_index;
    tlb_entry_t            tlbw_entry;
    bus_req_t              bus;
    logic [`ADDR_W-1:0]    bus_rdata;
    logic                  bus_streq;
    logic                  exc_tlbr;
    logic                  exc_tlbi;
    logic                  exc_tlbm;
    logic                  stallreq;

    vec_t        vecs[$];
    int          n_vec = 0;
    logic [15:0] lfsr = 16'd49309;

    mmu_top i_dut (.*);

    always #5 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_offset(output logic [11:0] off);
        for (int b = 0; b < 12; b++) begin
            lfsr   = lfsr_next(lfsr);
            off[b] = lfsr[0];               // one step per bit
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got %h expected %h", name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "value mismatch on %s", name);
        end
    endtask

    function automatic void add_write(input logic [2:0] idx, input logic [18:0] vpn2,
                                      input logic [7:0] id, input logic g,
                                      input tlb_page_t p0, input tlb_page_t p1);
        vec_t v;
        v            = '0;
        v.wr         = 1'b1;
        v.idx        = idx;
        v.ent.vpn2   = vpn2;
        v.ent.asid   = id;
        v.ent.g      = g;
        v.ent.page0  = p0;
        v.ent.page1  = p1;
        vecs.push_back(v);
    endfunction

    function automatic void add_access(input logic en, input logic [3:0] wen,
                                       input logic [31:0] va, input logic [1:0] side,
                                       input logic erl, input logic [2:0] k0,
                                       input logic [7:0] id, input logic mapped,
                                       input logic bus_en, input logic [31:0] pa,
                                       input logic cached, input logic [2:0] exc);
        vec_t v;
        v            = '0;
        v.en         = en;
        v.wen        = wen;
        v.vaddr      = va;
        v.exc_flag   = side[1];
        v.streq      = side[0];
        v.status     = 32'(erl) << `ST_ERL;
        v.cfg        = 32'(k0) << `CFG_K0_LSB;
        v.asid       = id;
        v.mapped     = mapped;
        v.exp_bus_en = bus_en;
        v.exp_pa     = pa;
        v.exp_cached = cached;
        v.exp_exc    = exc;
        vecs.push_back(v);
    endfunction

    // access columns: en, wen, page, {exc_flag, bus_streq}, erl, k0, asid,
    // mapped, bus_en, frame, cached, {tlbr, tlbi, tlbm}; pages are {pfn, c, d, v}
    task automatic build_table();
        add_access(1, 4'h0, 32'h8001_2000, 2'b00, 0, 3, 8'h05, 0, 1, 32'h0001_2000, 1, 3'b000);
        add_access(1, 4'h3, 32'h9fff_f000, 2'b00, 0, 2, 8'h05, 0, 1, 32'h1fff_f000, 0, 3'b000);
        add_access(1, 4'hf, 32'ha000_3000, 2'b00, 0, 3, 8'h05, 0, 1, 32'h0000_3000, 0, 3'b000);
        add_access(1, 4'h0, 32'hbfc0_0000, 2'b00, 0, 3, 8'h05, 0, 1, 32'h1fc0_0000, 0, 3'b000);
        add_access(1, 4'h0, 32'h0020_0000, 2'b00, 1, 3, 8'h05, 0, 1, 32'h0020_0000, 0, 3'b000);
        add_access(1, 4'hf, 32'hc123_4000, 2'b00, 1, 3, 8'h05, 0, 1, 32'h0123_4000, 0, 3'b000);
        add_access(1, 4'h0, 32'he800_0000, 2'b00, 1, 3, 8'h05, 0, 1, 32'h0800_0000, 0, 3'b000);
        add_write(0, 19'h00100, 8'h05, 0, {20'h12345, 5'b011_11}, {20'h0abcd, 5'b010_11});
        add_write(1, 19'h00200, 8'h05, 0, {20'h33333, 5'b011_01}, {20'h44444, 5'b011_10});
        add_write(2, 19'h00300, 8'h77, 1, {20'h55555, 5'b010_11}, {20'h66666, 5'b011_11});
        add_write(3, 19'h00400, 8'h09, 0, {20'h77777, 5'b011_11}, {20'h78787, 5'b011_11});
        add_write(4, 19'h60000, 8'h05, 0, {20'h01010, 5'b011_11}, {20'h02020, 5'b011_11});
        add_write(5, 19'h00500, 8'h00, 0, {20'h00000, 5'b000_00}, {20'h00000, 5'b000_00});
        add_write(6, 19'h00600, 8'h00, 0, {20'h00000, 5'b000_00}, {20'h00000, 5'b000_00});
        add_write(7, 19'h00700, 8'h00, 0, {20'h00000, 5'b000_00}, {20'h00000, 5'b000_00});
        add_access(1, 4'h0, 32'h0020_0000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h1234_5000, 1, 3'b000);
        add_access(1, 4'h0, 32'h0020_0000, 2'b00, 0, 3, 8'h05, 0, 1, 32'h1234_5000, 1, 3'b000);
        add_access(1, 4'hf, 32'h0020_1000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h0abc_d000, 0, 3'b000);
        add_access(1, 4'h1, 32'h0040_0000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h3333_3000, 1, 3'b001);
        add_access(1, 4'h0, 32'h0040_0000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h3333_3000, 1, 3'b000);
        add_access(1, 4'h0, 32'h0040_1000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h4444_4000, 1, 3'b010);
        add_access(1, 4'h0, 32'h0100_0000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h0000_0000, 0, 3'b100);
        add_access(1, 4'h0, 32'h0080_0000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h0000_0000, 0, 3'b100);
        add_access(1, 4'h0, 32'h0080_0000, 2'b00, 0, 3, 8'h09, 1, 1, 32'h7777_7000, 1, 3'b000);
        add_access(1, 4'h0, 32'h0060_1000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h6666_6000, 1, 3'b000);
        add_access(1, 4'h0, 32'h0060_0000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h5555_5000, 0, 3'b000);
        add_access(1, 4'hf, 32'hc000_0000, 2'b00, 0, 3, 8'h05, 1, 1, 32'h0101_0000, 1, 3'b000);
        add_access(1, 4'h0, 32'ha000_5000, 2'b10, 0, 3, 8'h05, 0, 0, 32'h0000_5000, 0, 3'b000);
        add_access(1, 4'h0, 32'h8000_6000, 2'b01, 0, 3, 8'h05, 0, 1, 32'h0000_6000, 1, 3'b000);
        add_access(0, 4'hf, 32'h0020_0000, 2'b00, 0, 3, 8'h05, 0, 0, 32'h0000_0000, 0, 3'b000);
        add_access(0, 4'hf, 32'h8000_7000, 2'b00, 0, 3, 8'h05, 0, 0, 32'h0000_0000, 0, 3'b000);
    endtask

    task automatic check_outputs(input vec_t v, input logic [11:0] off);
        check_value("stallreq", 32'(stallreq), 32'(v.streq));
        check_value("bus_en", 32'(bus.en), 32'(v.exp_bus_en));
        check_value("bus_wen", 32'(bus.wen), v.en ? 32'(v.wen) : 32'h0);
        check_value("bus_wdata", bus.wdata, req.wdata);
        check_value("rdata", rdata, v.en ? bus_rdata : 32'h0);
        check_value("exc_tlbr", 32'(exc_tlbr), 32'(v.exp_exc[2]));
        check_value("exc_tlbi", 32'(exc_tlbi), 32'(v.exp_exc[1]));
        check_value("exc_tlbm", 32'(exc_tlbm), 32'(v.exp_exc[0]));
        if (v.exp_bus_en && v.exp_exc == 3'b000) begin
            check_value("paddr", bus.paddr, {v.exp_pa[31:12], off});
            check_value("cached", 32'(bus.cached), 32'(v.exp_cached));
        end
    endtask

    // a mapped access is held through its stall cycle and sampled after it
    task automatic apply_vector(input vec_t v);
        logic [11:0] off;
        @(negedge clk);
        tlbw_en    = v.wr;
        tlbw_index = v.idx;
        tlbw_entry = v.ent;
        exc_flag   = v.exc_flag;
        bus_streq  = v.streq;
        cp0_status = v.status;
        cp0_config = v.cfg;
        asid       = v.asid;
        req        = '0;
        if (!v.wr) begin
            draw_offset(off);
            req.en    = v.en;
            req.wen   = v.wen;
            req.vaddr = {v.vaddr[31:12], off};
            req.wdata = ~req.vaddr;
            bus_rdata = {req.vaddr[15:0], req.vaddr[31:16]};
            #2;
            if (v.mapped) begin
                check_value("stallreq", 32'(stallreq), 32'(1'b1));
                @(negedge clk);
                #2;
            end
            check_outputs(v, off);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        req        = '0;
        exc_flag   = 1'b0;
        cp0_status = '0;
        cp0_config = '0;
        asid       = '0;
        tlbw_en    = 1'b0;
        tlbw_index = '0;
        tlbw_entry = '0;
        bus_rdata  = '0;
        bus_streq  = 1'b0;
        build_table();
        n_vec = vecs.size();
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        foreach (vecs[i]) apply_vector(vecs[i]);
        @(negedge clk);
        tlbw_en = 1'b0;
        req     = '0;
        $display("*** TEST PASSED ***");
        $finish;
    end

    // four cycles per row plus the reset phase
    initial begin
        wait (n_vec > 0);
        #(n_vec * 40 + 100);
        $display("timeout, the vector table did not complete in time");
        $display("*** TEST FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

/* design/mmu_top.sv */
// MMU top level, translator plus joint TLB
// the core presents one access per cycle and holds it while stallreq is high
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_top import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_req_t              req,
    output logic [`ADDR_W-1:0]    rdata,
    input  logic                  exc_flag,
    input  logic [`ADDR_W-1:0]    cp0_status,
    input  logic [`ADDR_W-1:0]    cp0_config,
    input  logic [`ASID_W-1:0]    asid,
    input  logic                  tlbw_en,
    input  logic [`TLB_IDX_W-1:0] tlbw_index,
    input  tlb_entry_t            tlbw_entry,
    output bus_req_t              bus,
    input  logic [`ADDR_W-1:0]    bus_rdata,
    input  logic                  bus_streq,
    output logic                  exc_tlbr,
    output logic                  exc_tlbi,
    output logic                  exc_tlbm,
    output logic                  stallreq
);

    logic                    tlb_en;
    logic                    tlb_rdy;
    tlb_key_t                xlate_key;
    tlb_key_t                lookup_key;
    tlb_key_t                cur_key;
    tlb_result_t             tlb_res;
    lookup_state_t           state;
    logic [`TLB_ENTRIES-1:0] ent_we;
    tlb_entry_t              ent_wdata;
    logic [`TLB_ENTRIES-1:0] match;
    tlb_page_t               pages [`TLB_ENTRIES];

    // current ASID joins the key here
    assign lookup_key.vpn2 = xlate_key.vpn2;
    assign lookup_key.odd  = xlate_key.odd;
    assign lookup_key.asid = asid;
    assign lookup_key.refs = xlate_key.refs;

    addr_xlate i_xlate (
        .req        (req),
        .exc_flag   (exc_flag),
        .cp0_status (cp0_status),
        .cp0_config (cp0_config),
        .tlb_rdy    (tlb_rdy),
        .tlb_res    (tlb_res),
        .bus        (bus),
        .rdata      (rdata),
        .bus_rdata  (bus_rdata),
        .bus_streq  (bus_streq),
        .tlb_en     (tlb_en),
        .tlb_key    (xlate_key),
        .exc_tlbr   (exc_tlbr),
        .exc_tlbi   (exc_tlbi),
        .exc_tlbm   (exc_tlbm),
        .stallreq   (stallreq)
    );

    tlb_lookup_ctl i_lookup (
        .clk        (clk),
        .rst        (rst),
        .tlb_en     (tlb_en),
        .key        (lookup_key),
        .tlbw_en    (tlbw_en),
        .tlbw_index (tlbw_index),
        .tlbw_entry (tlbw_entry),
        .cur_key    (cur_key),
        .state      (state),
        .ent_we     (ent_we),
        .ent_wdata  (ent_wdata)
    );

    for (genvar i = 0; i < `TLB_ENTRIES; i++) begin : g_ent
        tlb_entry i_ent (
            .clk   (clk),
            .rst   (rst),
            .we    (ent_we[i]),
            .wdata (ent_wdata),
            .key   (cur_key),
            .match (match[i]),
            .page  (pages[i])
        );
    end

    tlb_hit_merge i_merge (
        .key     (cur_key),
        .state   (state),
        .tlb_en  (tlb_en),
        .match   (match),
        .pages   (pages),
        .tlb_rdy (tlb_rdy),
        .res     (tlb_res)
    );

endmodule

/* design/tlb_hit_merge.sv */
// merges the match vector of the TLB entries into one translation
// also produces the ready level and the refill/invalid/modified flags
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_hit_merge import mmu_pkg::*; (
    input  tlb_key_t                key,
    input  lookup_state_t           state,
    input  logic                    tlb_en,
    input  logic [`TLB_ENTRIES-1:0] match,
    input  tlb_page_t               pages [`TLB_ENTRIES],
    output logic                    tlb_rdy,
    output tlb_result_t             res
);

    tlb_page_t sel;
    logic      hit;

    // and-or select, at most one entry matches
    always_comb begin
        sel = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (match[i])
                sel = sel | pages[i];
        end
    end

    assign hit     = |match;
    assign tlb_rdy = tlb_en && state == lk_ready;

    // frame base only, the translator adds the byte offset
    assign res.paddr  = {sel.pfn, 12'h000};
    assign res.cached = sel.c == 3'd3;

    // fault flags, each only once the lookup is ready
    always_comb begin
        res.refill   = 1'b0;
        res.invalid  = 1'b0;
        res.modified = 1'b0;
        if (tlb_rdy) begin
            if (!hit)
                res.refill = 1'b1;          // no entry for this page
            else if (!sel.v)
                res.invalid = 1'b1;
            else if (key.refs && !sel.d)
                res.modified = 1'b1;        // store to a clean page
        end
    end

    // duplicate entries would corrupt the and-or select
    always_comb begin
        if (tlb_rdy)
            assert ($onehot0(match))
                else $error("multiple TLB entries match vpn2 %h", key.vpn2);
    end

endmodule

/* design/tlb_entry.sv */
// one fully associative TLB entry
// holds VPN2, ASID, G and the even/odd page pair, compares against the key
`timescale 1ns/1ps

module tlb_entry import mmu_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       we,
    input  tlb_entry_t wdata,
    input  tlb_key_t   key,
    output logic       match,
    output tlb_page_t  page
);

    tlb_entry_t ent_q;
    logic       vpn_eq;
    logic       asid_eq;

    // only the valid bits are cleared, the rest is loaded by software
    always_ff @(posedge clk) begin
        if (rst) begin
            ent_q.page0.v <= 1'b0;
            ent_q.page1.v <= 1'b0;
        end else if (we) begin
            ent_q <= wdata;
        end
    end

    assign vpn_eq  = ent_q.vpn2 == key.vpn2;
    assign asid_eq = ent_q.asid == key.asid;

    assign match = vpn_eq && (ent_q.g || asid_eq);  // global entries ignore ASID

    // bit 12 picks the odd page
    assign page = key.odd ? ent_q.page1 : ent_q.page0;

endmodule

/* design/tlb_lookup_ctl.sv */
// lookup sequencer of the joint TLB
// registers the key for the entry array and turns indexed writes into strobes
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb_lookup_ctl import mmu_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tlb_en,
    input  tlb_key_t              key,
    input  logic                  tlbw_en,
    input  logic [`TLB_IDX_W-1:0] tlbw_index,
    input  tlb_entry_t            tlbw_entry,
    output tlb_key_t              cur_key,
    output lookup_state_t         state,
    output logic [`TLB_ENTRIES-1:0] ent_we,
    output tlb_entry_t            ent_wdata
);

    lookup_state_t st_q;
    logic          key_same;

    assign key_same = key == cur_key;

    // the registered state only counts while the same key is still presented
    // and no entry is being rewritten, anything else reads as idle
    assign state = (st_q == lk_ready && key_same && tlb_en && !tlbw_en) ?
                   lk_ready : lk_idle;

    always_ff @(posedge clk) begin
        if (rst)
            st_q <= lk_idle;
        else if (tlb_en)
            st_q <= lk_ready;               // key captured this edge
        else
            st_q <= lk_idle;
    end

    always_ff @(posedge clk) begin
        if (tlb_en)
            cur_key <= key;                 // unchanged value while ready
    end

    // one strobe per entry
    always_comb begin
        ent_we = '0;
        if (tlbw_en)
            ent_we[tlbw_index] = 1'b1;
    end

    assign ent_wdata = tlbw_entry;          // same data to every entry

    // a write must address an existing entry
    a_wr_index: assert property (
        @(posedge clk) disable iff (rst)
        tlbw_en |-> (tlbw_index < `TLB_ENTRIES)
    ) else $error("TLB write index %0d out of range", tlbw_index);

endmodule

/* design/addr_xlate.sv */
// segment decoder for memory stage accesses
// unmapped segments translate in the same cycle, mapped ones wait on the TLB
`timescale 1ns/1ps
`include "mmu_defs.svh"

module addr_xlate import mmu_pkg::*; (
    input  mem_req_t           req,
    input  logic               exc_flag,
    input  logic [`ADDR_W-1:0] cp0_status,
    input  logic [`ADDR_W-1:0] cp0_config,
    input  logic               tlb_rdy,
    input  tlb_result_t        tlb_res,
    output bus_req_t           bus,
    output logic [`ADDR_W-1:0] rdata,
    input  logic [`ADDR_W-1:0] bus_rdata,
    input  logic               bus_streq,
    output logic               tlb_en,
    output tlb_key_t           tlb_key,
    output logic               exc_tlbr,
    output logic               exc_tlbi,
    output logic               exc_tlbm,
    output logic               stallreq
);

    seg_kind_t          seg;
    logic               erl;
    logic [`ADDR_W-1:0] direct_pa;
    logic               tlb_streq;

    assign erl       = cp0_status[`ST_ERL];
    assign direct_pa = {3'b000, req.vaddr[`ADDR_W-4:0]};  // drop the segment bits

    always_comb begin
        if (!req.vaddr[`ADDR_W-1])
            seg = seg_kuseg;
        else if (req.vaddr[`ADDR_W-1 -: 3] == `SEG_KSEG0)
            seg = seg_kseg0;
        else if (req.vaddr[`ADDR_W-1 -: 3] == `SEG_KSEG1)
            seg = seg_kseg1;
        else
            seg = seg_kseg23;
    end

    // key is formed from vaddr all the time so it stays stable under a stall
    assign tlb_key.vpn2 = req.vaddr[`ADDR_W-1:13];
    assign tlb_key.odd  = req.vaddr[12];
    assign tlb_key.asid = '0;                   // filled in at the top level
    assign tlb_key.refs = req.wen != 4'b0000;

    assign bus.wen   = req.en ? req.wen : 4'b0000;
    assign bus.wdata = req.wdata;
    assign rdata     = req.en ? bus_rdata : '0;
    assign stallreq  = bus_streq || tlb_streq;

    always_comb begin
        tlb_en     = 1'b0;
        tlb_streq  = 1'b0;
        bus.en     = 1'b0;
        bus.paddr  = direct_pa;
        bus.cached = 1'b0;
        exc_tlbr   = 1'b0;
        exc_tlbi   = 1'b0;
        exc_tlbm   = 1'b0;

        case (seg)
            seg_kseg0: begin
                bus.en     = req.en && !exc_flag;
                bus.cached = cp0_config[`CFG_K0_LSB +: 3] == 3'd3;
            end
            seg_kseg1: begin
                bus.en = req.en && !exc_flag;   // always uncached
            end
            default: begin
                if (erl) begin
                    bus.en = req.en && !exc_flag;   // error level, direct and uncached
                end else if (req.en) begin
                    tlb_en     = 1'b1;
                    tlb_streq  = !tlb_rdy;
                    bus.en     = tlb_rdy && !exc_flag;
                    bus.paddr  = {tlb_res.paddr[`ADDR_W-1:12], req.vaddr[11:0]};
                    bus.cached = tlb_res.cached;
                    exc_tlbr   = tlb_res.refill;    // flags already qualified by tlb_rdy
                    exc_tlbi   = tlb_res.invalid;
                    exc_tlbm   = tlb_res.modified;
                end
            end
        endcase
    end

    // a fault may only come from a completed lookup of the presented key
    always_comb begin
        if (exc_tlbr || exc_tlbi || exc_tlbm)
            assert (tlb_rdy && tlb_en)
                else $error("TLB exception raised without a ready lookup");
    end

endmodule

/* design/mmu_pkg.sv */
// types shared by the MMU RTL and its testbench
// modules take them with a wildcard import in the module header
`include "mmu_defs.svh"

package mmu_pkg;

    // address segment of a virtual access
    typedef enum logic [1:0] {
        seg_kuseg,
        seg_kseg0,
        seg_kseg1,
        seg_kseg23      // kseg2 and kseg3 share one route
    } seg_kind_t;

    typedef enum logic {
        lk_idle,
        lk_ready
    } lookup_state_t;

    typedef struct packed {
        logic [`ADDR_W-13:0] pfn;   // 4 KB frame number
        logic [2:0]          c;     // cache attribute
        logic                d;     // dirty, page is writable
        logic                v;
    } tlb_page_t;

    typedef struct packed {
        logic [`ADDR_W-14:0] vpn2;  // covers an even/odd page pair
        logic [`ASID_W-1:0]  asid;
        logic                g;
        tlb_page_t           page0; // even page
        tlb_page_t           page1; // odd page
    } tlb_entry_t;

    typedef struct packed {
        logic [`ADDR_W-14:0] vpn2;
        logic                odd;   // vaddr bit 12
        logic [`ASID_W-1:0]  asid;
        logic                refs;  // access is a store
    } tlb_key_t;

    typedef struct packed {
        logic [`ADDR_W-1:0] paddr;
        logic               cached;
        logic               refill;
        logic               invalid;
        logic               modified;
    } tlb_result_t;

    typedef struct packed {
        logic               en;
        logic [3:0]         wen;    // byte write enables
        logic [`ADDR_W-1:0] vaddr;
        logic [`ADDR_W-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic               en;
        logic [3:0]         wen;
        logic [`ADDR_W-1:0] paddr;
        logic [`ADDR_W-1:0] wdata;
        logic               cached;
    } bus_req_t;

endpackage

/* design/mmu_defs.svh */
// address map, TLB geometry and CP0 field positions for the MMU
// include wherever a width, segment code or CP0 bit position is needed
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

`define ADDR_W      32      // address and data width
`define TLB_ENTRIES 8       // joint TLB entries
`define TLB_IDX_W   3       // TLB index width

`define ASID_W      8

// vaddr[31:29] of the unmapped kernel segments
`define SEG_KSEG0   3'b100
`define SEG_KSEG1   3'b101

`define CFG_K0_LSB  0       // Config.K0, 3 bits
`define CFG_KU_LSB  25      // Config.KU, 3 bits
`define CFG_K23_LSB 28      // Config.K23, 3 bits
`define ST_ERL      2       // Status.ERL

`endif
